//--- source/raycastCfg.svh
`ifndef RAYCAST_CFG_SVH
`define RAYCAST_CFG_SVH

// map geometry, square map of MAP_SIZE tiles per side
`define MAP_SIZE      24
`define MAP_TILES     576  // MAP_SIZE * MAP_SIZE
`define MAP_ADDR_W    10
`define TILE_W        4    // zero is an empty tile

// screen
`define SCREEN_HEIGHT 240
`define HCOUNT_W      9

// unsigned 8.8 fixed point
`define FIX_W         16
`define FIX_FRAC      8

// apb address layout, tiles start at 0
`define APB_ADDR_W    12
`define APB_DATA_W    32
`define STATUS_ADDR   12'h400

`endif

//--- source/rayPkg.sv
`default_nettype none

package rayPkg;

  // dda engine FSM
  typedef enum logic [2:0] {
    IDLE,        // waiting for a ray
    LOAD,        // tile coords from position
    X_STEP,      // advance one tile in x
    Y_STEP,      // advance one tile in y
    CHECK_WALL,  // wait for the tile lookup
    DIVIDE,      // line height division running
    HOLD         // result waiting for the sequencer
  } ddaState;

  // which wall face the ray crossed last
  typedef enum logic {
    SIDE_X,
    SIDE_Y
  } wallSide;

endpackage

`default_nettype wire

//--- source/busPkg.sv
`default_nettype none

package busPkg;

  // decode of an apb address
  typedef enum logic [1:0] {
    REGION_MAP,     // tile storage
    REGION_STATUS,  // engine busy flags
    REGION_NONE     // unmapped, slave error
  } apbRegion;

  // status register layout
  localparam int STATUS_BUSY0 = 0;
  localparam int STATUS_BUSY1 = 1;

endpackage

`default_nettype wire

//--- source/fixedDivider.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module fixedDivider (
  input  logic pixel_clk_in,
  input  logic rst_in,
  input  logic start,
  input  logic [`FIX_W-1:0] numerator,
  input  logic [`FIX_W-1:0] denominator,
  output logic [`FIX_W-1:0] quotient,
  output logic done,
  output logic ovf
);

  localparam int quoW = `FIX_W + `FIX_FRAC;  // dividend is numerator << FIX_FRAC

  logic [quoW-1:0] quoReg;
  logic [quoW-1:0] quoSrc;
  logic [quoW-1:0] quoNext;
  logic [`FIX_W-1:0] remReg;
  logic [`FIX_W-1:0] remSrc;
  logic [`FIX_W-1:0] remNext;
  logic [`FIX_W-1:0] denReg;
  logic [`FIX_W-1:0] denSrc;
  logic [`FIX_W:0] trial;     // shifted remainder, one bit wider
  logic [`FIX_W:0] diff;
  logic [4:0] iter;           // iterations done so far
  logic running;

  // one restoring step, first step runs straight off the inputs
  always_comb begin
    remSrc = start ? '0 : remReg;
    quoSrc = start ? {numerator, {`FIX_FRAC{1'b0}}} : quoReg;
    denSrc = start ? denominator : denReg;
    trial = {remSrc, quoSrc[quoW-1]};
    diff = trial - {1'b0, denSrc};
    if (trial >= {1'b0, denSrc}) begin
      remNext = diff[`FIX_W-1:0];          // fits, keep the difference
      quoNext = {quoSrc[quoW-2:0], 1'b1};
    end else begin
      remNext = trial[`FIX_W-1:0];
      quoNext = {quoSrc[quoW-2:0], 1'b0};
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      running <= 1'b0;
      done <= 1'b0;
      iter <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        iter <= 5'd1;
      end else if (running) begin
        iter <= iter + 5'd1;
        if (iter == 5'(quoW - 1)) begin  // last quotient bit this cycle
          running <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (start || running) begin
      remReg <= remNext;
      quoReg <= quoNext;
    end
    if (start) denReg <= denominator;
  end

  assign quotient = quoReg[`FIX_W-1:0];
  // zero divisor or integer part wider than 8 bits
  assign ovf = (denReg == '0) || (|quoReg[quoW-1:`FIX_W]);

endmodule

`default_nettype wire

//--- source/ddaEngine.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module ddaEngine (
  input  logic pixel_clk_in,
  input  logic rst_in,
  input  logic engValid,
  output logic engReady,
  input  logic [`HCOUNT_W-1:0] hcount,
  input  logic stepX,             // 1 -> +1, 0 -> -1
  input  logic stepY,
  input  logic [`FIX_W-1:0] deltaDistX,
  input  logic [`FIX_W-1:0] deltaDistY,
  input  logic [`FIX_W-1:0] posX,
  input  logic [`FIX_W-1:0] posY,
  input  logic [`FIX_W-1:0] sideDistX,
  input  logic [`FIX_W-1:0] sideDistY,
  output logic [`MAP_ADDR_W-1:0] mapAddr,
  output logic mapReq,
  input  logic [`TILE_W-1:0] mapTile,
  input  logic mapTileValid,
  output logic resValid,
  input  logic resReady,
  output logic [`HCOUNT_W-1:0] resHcount,
  output logic [7:0] lineHeight,
  output rayPkg::wallSide resSide,
  output logic [`TILE_W-1:0] resTile,
  output logic busy
);

  import rayPkg::*;

  localparam int coordW = `FIX_W - `FIX_FRAC;                 // integer part of a position
  localparam logic [`FIX_W-1:0] heightFix = `SCREEN_HEIGHT << `FIX_FRAC;  // 240.0
  localparam logic [7:0] heightClamp = `SCREEN_HEIGHT;
  localparam logic [`MAP_ADDR_W-1:0] rowPitch = `MAP_SIZE;

  ddaState state;
  ddaState stepState;
  logic rayStepX;
  logic rayStepY;
  logic [`FIX_W-1:0] rayDeltaX;
  logic [`FIX_W-1:0] rayDeltaY;
  logic [`FIX_W-1:0] rayPosX;
  logic [`FIX_W-1:0] rayPosY;
  logic [`FIX_W-1:0] sideX;      // running side distances
  logic [`FIX_W-1:0] sideY;
  logic [coordW-1:0] mapX;
  logic [coordW-1:0] mapY;
  logic [coordW-1:0] nextX;
  logic [coordW-1:0] nextY;
  logic divStart;
  logic divDone;
  logic divOvf;
  logic [`FIX_W-1:0] divDen;     // perpendicular wall distance
  logic [`FIX_W-1:0] divQuot;
  logic [coordW-1:0] quotInt;

  // tile index = x + y * MAP_SIZE
  function automatic logic [`MAP_ADDR_W-1:0] tileIndex(input logic [coordW-1:0] x,
                                                        input logic [coordW-1:0] y);
    logic [`MAP_ADDR_W-1:0] xa;
    logic [`MAP_ADDR_W-1:0] ya;
    xa = x;
    ya = y;
    return xa + ya * rowPitch;
  endfunction

  assign nextX = rayStepX ? mapX + 1'b1 : mapX - 1'b1;
  assign nextY = rayStepY ? mapY + 1'b1 : mapY - 1'b1;
  assign stepState = (sideX < sideY) ? X_STEP : Y_STEP;  // ties go to y
  assign quotInt = divQuot[`FIX_W-1:`FIX_FRAC];
  assign busy = (state != IDLE);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      engReady <= 1'b0;  // rises on the first cycle out of reset
      resValid <= 1'b0;
      mapReq <= 1'b0;
      divStart <= 1'b0;
    end else begin
      mapReq <= 1'b0;    // both are single-cycle pulses
      divStart <= 1'b0;
      case (state)
        IDLE: begin
          if (engValid && engReady) begin
            engReady <= 1'b0;
            resHcount <= hcount;  // ray captured on accept, source may move on
            rayStepX <= stepX;
            rayStepY <= stepY;
            rayDeltaX <= deltaDistX;
            rayDeltaY <= deltaDistY;
            rayPosX <= posX;
            rayPosY <= posY;
            sideX <= sideDistX;
            sideY <= sideDistY;
            state <= LOAD;
          end else begin
            engReady <= 1'b1;
          end
        end
        LOAD: begin
          mapX <= rayPosX[`FIX_W-1:`FIX_FRAC];  // start tile holds the player
          mapY <= rayPosY[`FIX_W-1:`FIX_FRAC];
          state <= stepState;
        end
        X_STEP: begin
          sideX <= sideX + rayDeltaX;
          mapX <= nextX;
          resSide <= SIDE_X;
          mapAddr <= tileIndex(nextX, mapY);
          mapReq <= 1'b1;
          state <= CHECK_WALL;
        end
        Y_STEP: begin
          sideY <= sideY + rayDeltaY;
          mapY <= nextY;
          resSide <= SIDE_Y;
          mapAddr <= tileIndex(mapX, nextY);
          mapReq <= 1'b1;
          state <= CHECK_WALL;
        end
        CHECK_WALL: begin
          if (mapTileValid) begin  // tile arrives one cycle after the request
            if (mapTile != '0) begin
              resTile <= mapTile;
              // step back one delta to get the distance to the face that was hit
              divDen <= (resSide == SIDE_X) ? sideX - rayDeltaX : sideY - rayDeltaY;
              divStart <= 1'b1;
              state <= DIVIDE;
            end else begin
              state <= stepState;
            end
          end
        end
        DIVIDE: begin
          if (divDone) begin
            // very close walls overflow, clamp to full screen
            lineHeight <= (divOvf || quotInt >= heightClamp) ? heightClamp : quotInt;
            resValid <= 1'b1;
            state <= HOLD;
          end
        end
        HOLD: begin
          if (resReady) begin
            resValid <= 1'b0;
            engReady <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  fixedDivider divider (
    .pixel_clk_in(pixel_clk_in),
    .rst_in(rst_in),
    .start(divStart),
    .numerator(heightFix),
    .denominator(divDen),
    .quotient(divQuot),
    .done(divDone),
    .ovf(divOvf)
  );

endmodule

`default_nettype wire

//--- source/mapMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module mapMemory (
  input  logic pixel_clk_in,
  input  logic rst_in,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`APB_DATA_W-1:0] pwdata,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic pready,
  output logic pslverr,
  input  logic [`MAP_ADDR_W-1:0] mapAddr0,
  input  logic mapReq0,
  output logic [`TILE_W-1:0] mapTile0,
  output logic mapTileValid0,
  input  logic [`MAP_ADDR_W-1:0] mapAddr1,
  input  logic mapReq1,
  output logic [`TILE_W-1:0] mapTile1,
  output logic mapTileValid1,
  input  logic busy0,
  input  logic busy1
);

  import busPkg::*;

  logic [`TILE_W-1:0] tiles [`MAP_TILES];
  apbRegion region;
  logic access;  // apb access phase

  assign access = psel && penable;
  assign pready = access;  // no wait states
  assign pslverr = access && (region == REGION_NONE);

  always_comb begin
    if (paddr < `MAP_TILES) region = REGION_MAP;
    else if (paddr == `STATUS_ADDR) region = REGION_STATUS;
    else region = REGION_NONE;
  end

  // read data, zero for unmapped addresses
  always_comb begin
    prdata = '0;
    case (region)
      REGION_MAP: prdata[`TILE_W-1:0] = tiles[paddr[`MAP_ADDR_W-1:0]];
      REGION_STATUS: begin
        prdata[STATUS_BUSY0] = busy0;
        prdata[STATUS_BUSY1] = busy1;
      end
      default: prdata = '0;
    endcase
  end

  always_ff @(posedge pixel_clk_in) begin
    if (access && pwrite && region == REGION_MAP) begin
      tiles[paddr[`MAP_ADDR_W-1:0]] <= pwdata[`TILE_W-1:0];  // visible next cycle
    end
    if (mapReq0) mapTile0 <= tiles[mapAddr0];  // engine read ports, 1 cycle
    if (mapReq1) mapTile1 <= tiles[mapAddr1];
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      mapTileValid0 <= 1'b0;
      mapTileValid1 <= 1'b0;
    end else begin
      mapTileValid0 <= mapReq0;
      mapTileValid1 <= mapReq1;
    end
  end

endmodule

`default_nettype wire

//--- source/columnSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module columnSequencer (
  input  logic pixel_clk_in,
  input  logic rst_in,
  // ray input
  input  logic rayValid,
  output logic rayReady,
  input  logic [`HCOUNT_W-1:0] hcount,
  input  logic stepX, stepY,
  input  logic [`FIX_W-1:0] deltaDistX, deltaDistY, posX, posY, sideDistX, sideDistY,
  // column output
  output logic colValid,
  input  logic colReady,
  output logic [`HCOUNT_W-1:0] colHcount,
  output logic [7:0] lineHeight,
  output rayPkg::wallSide colSide,
  output logic [`TILE_W-1:0] colTile,
  // engine 0
  output logic engValid0,
  input  logic engReady0,
  output logic [`HCOUNT_W-1:0] engHcount0,
  output logic engStepX0, engStepY0,
  output logic [`FIX_W-1:0] engDeltaDistX0, engDeltaDistY0, engPosX0, engPosY0,
  output logic [`FIX_W-1:0] engSideDistX0, engSideDistY0,
  input  logic resValid0,
  output logic resReady0,
  input  logic [`HCOUNT_W-1:0] resHcount0,
  input  logic [7:0] resLineHeight0,
  input  rayPkg::wallSide resSide0,
  input  logic [`TILE_W-1:0] resTile0,
  // engine 1
  output logic engValid1,
  input  logic engReady1,
  output logic [`HCOUNT_W-1:0] engHcount1,
  output logic engStepX1, engStepY1,
  output logic [`FIX_W-1:0] engDeltaDistX1, engDeltaDistY1, engPosX1, engPosY1,
  output logic [`FIX_W-1:0] engSideDistX1, engSideDistY1,
  input  logic resValid1,
  output logic resReady1,
  input  logic [`HCOUNT_W-1:0] resHcount1,
  input  logic [7:0] resLineHeight1,
  input  rayPkg::wallSide resSide1,
  input  logic [`TILE_W-1:0] resTile1
);

  logic dispPar;  // engine for the next ray
  logic collPar;  // engine whose result is due next
  logic outFree;
  logic take;

  // even rays to engine 0, odd rays to engine 1
  assign rayReady = dispPar ? engReady1 : engReady0;
  assign engValid0 = rayValid && !dispPar;
  assign engValid1 = rayValid && dispPar;
  assign {engHcount0, engStepX0, engStepY0} = {hcount, stepX, stepY};
  assign {engHcount1, engStepX1, engStepY1} = {hcount, stepX, stepY};
  assign {engDeltaDistX0, engDeltaDistY0, engPosX0, engPosY0} = {deltaDistX, deltaDistY, posX, posY};
  assign {engDeltaDistX1, engDeltaDistY1, engPosX1, engPosY1} = {deltaDistX, deltaDistY, posX, posY};
  assign {engSideDistX0, engSideDistY0} = {sideDistX, sideDistY};
  assign {engSideDistX1, engSideDistY1} = {sideDistX, sideDistY};

  // only the expected engine may hand over, keeps column order
  assign outFree = !colValid || colReady;
  assign take = outFree && (collPar ? resValid1 : resValid0);
  assign resReady0 = take && !collPar;
  assign resReady1 = take && collPar;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      dispPar <= 1'b0;
      collPar <= 1'b0;
      colValid <= 1'b0;
    end else begin
      if (rayValid && rayReady) dispPar <= !dispPar;
      if (take) begin
        collPar <= !collPar;
        colValid <= 1'b1;
      end else if (colReady) begin
        colValid <= 1'b0;  // drained, nothing new
      end
    end
  end

  // output register, held while colReady is low
  always_ff @(posedge pixel_clk_in) begin
    if (take) begin
      colHcount <= collPar ? resHcount1 : resHcount0;
      lineHeight <= collPar ? resLineHeight1 : resLineHeight0;
      colSide <= collPar ? resSide1 : resSide0;
      colTile <= collPar ? resTile1 : resTile0;
    end
  end

endmodule

`default_nettype wire

//--- source/raycasterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module raycasterTop (
  input  logic pixel_clk_in,
  input  logic rst_in,
  // apb, map access and status
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`APB_DATA_W-1:0] pwdata,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic pready,
  output logic pslverr,
  // one ray per screen column
  input  logic rayValid,
  output logic rayReady,
  input  logic [`HCOUNT_W-1:0] hcount,
  input  logic stepX,
  input  logic stepY,
  input  logic [`FIX_W-1:0] deltaDistX,
  input  logic [`FIX_W-1:0] deltaDistY,
  input  logic [`FIX_W-1:0] posX,
  input  logic [`FIX_W-1:0] posY,
  input  logic [`FIX_W-1:0] sideDistX,
  input  logic [`FIX_W-1:0] sideDistY,
  // results in column order
  output logic colValid,
  input  logic colReady,
  output logic [`HCOUNT_W-1:0] colHcount,
  output logic [7:0] lineHeight,
  output rayPkg::wallSide colSide,
  output logic [`TILE_W-1:0] colTile
);

  import rayPkg::*;

  logic engValid0, engReady0, engStepX0, engStepY0;
  logic engValid1, engReady1, engStepX1, engStepY1;
  logic [`HCOUNT_W-1:0] engHcount0, engHcount1, resHcount0, resHcount1;
  logic [`FIX_W-1:0] engDeltaDistX0, engDeltaDistY0, engPosX0, engPosY0;
  logic [`FIX_W-1:0] engDeltaDistX1, engDeltaDistY1, engPosX1, engPosY1;
  logic [`FIX_W-1:0] engSideDistX0, engSideDistY0, engSideDistX1, engSideDistY1;
  logic resValid0, resReady0, resValid1, resReady1;
  logic [7:0] resLineHeight0, resLineHeight1;
  wallSide resSide0, resSide1;
  logic [`TILE_W-1:0] resTile0, resTile1, mapTile0, mapTile1;
  logic [`MAP_ADDR_W-1:0] mapAddr0, mapAddr1;
  logic mapReq0, mapReq1, mapTileValid0, mapTileValid1, busy0, busy1;

  // names match port for port
  columnSequencer sequencer (.*);

  mapMemory map (.*);

  ddaEngine engine0 (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .engValid(engValid0), .engReady(engReady0), .hcount(engHcount0),
    .stepX(engStepX0), .stepY(engStepY0),
    .deltaDistX(engDeltaDistX0), .deltaDistY(engDeltaDistY0),
    .posX(engPosX0), .posY(engPosY0),
    .sideDistX(engSideDistX0), .sideDistY(engSideDistY0),
    .mapAddr(mapAddr0), .mapReq(mapReq0), .mapTile(mapTile0), .mapTileValid(mapTileValid0),
    .resValid(resValid0), .resReady(resReady0), .resHcount(resHcount0),
    .lineHeight(resLineHeight0), .resSide(resSide0), .resTile(resTile0), .busy(busy0)
  );

  ddaEngine engine1 (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .engValid(engValid1), .engReady(engReady1), .hcount(engHcount1),
    .stepX(engStepX1), .stepY(engStepY1),
    .deltaDistX(engDeltaDistX1), .deltaDistY(engDeltaDistY1),
    .posX(engPosX1), .posY(engPosY1),
    .sideDistX(engSideDistX1), .sideDistY(engSideDistY1),
    .mapAddr(mapAddr1), .mapReq(mapReq1), .mapTile(mapTile1), .mapTileValid(mapTileValid1),
    .resValid(resValid1), .resReady(resReady1), .resHcount(resHcount1),
    .lineHeight(resLineHeight1), .resSide(resSide1), .resTile(resTile1), .busy(busy1)
  );

endmodule

`default_nettype wire

//--- test/raycasterTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "raycastCfg.svh"

module raycasterTb;

  import rayPkg::*;
  import busPkg::*;

  localparam int numRays = 309;  // 1 + 200 + 100 + 8 over tests 2 to 5
  localparam int cycleLimit = numRays * (3 * 48 + 30) + 2000;

  logic pixel_clk_in;
  logic rst_in;
  logic psel, penable, pwrite, pready, pslverr;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`APB_DATA_W-1:0] pwdata, prdata;
  logic rayValid, rayReady, stepX, stepY;
  logic [`HCOUNT_W-1:0] hcount, colHcount;
  logic [`FIX_W-1:0] deltaDistX, deltaDistY, posX, posY, sideDistX, sideDistY;
  logic colValid, colReady;
  logic [7:0] lineHeight;
  wallSide colSide;
  logic [`TILE_W-1:0] colTile;

  logic [`TILE_W-1:0] tbMap [`MAP_TILES];  // mirror of the tile store
  logic [21:0] expQ [$];                    // {hcount, height, side, tile} in accept order
  int errCount, passCount, failCount, errBefore;
  int sentCount, colCount, cycles;
  logic randomReady, wallTest, holding;
  logic [21:0] heldCol, gotCol, expCol;
  logic [`HCOUNT_W-1:0] colIdx;
  logic [31:0] rdata;
  logic err;

  raycasterTop dut (.*);

  initial begin
    pixel_clk_in = 1'b0;
    forever #50 pixel_clk_in = ~pixel_clk_in;
  end

  // one apb transfer, enters and leaves 1 ns after a rising edge
  task automatic apbAccess(input logic write, input logic [11:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rd, output logic e);
    psel = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge pixel_clk_in);
    #1;
    penable = 1'b1;  // access phase
    @(negedge pixel_clk_in);
    checkVal("pready in access phase", pready, 1);  // no wait states
    rd = prdata;
    e = pslverr;
    @(posedge pixel_clk_in);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  // dda walk plus divide and clamp, as the engine should do it
  task automatic modelRay(input logic sx, input logic sy, input int dx, input int dy,
                          input int px, input int py, input int sdx, input int sdy,
                          output logic [7:0] h, output logic s, output logic [3:0] t);
    int mx, my, den, q, steps;
    mx = px >> 8;  // start tile
    my = py >> 8;
    s = 1'b0;
    t = '0;
    steps = 0;
    while (t == 0 && steps < 48) begin
      if (sdx < sdy) begin
        sdx += dx;
        mx += sx ? 1 : -1;
        s = 1'b0;
      end else begin  // ties step in y
        sdy += dy;
        my += sy ? 1 : -1;
        s = 1'b1;
      end
      t = tbMap[mx + my * `MAP_SIZE];
      steps++;
    end
    den = s ? sdy - dy : sdx - dx;  // perpendicular distance, 8.8
    if (den == 0) h = `SCREEN_HEIGHT;
    else begin
      q = (`SCREEN_HEIGHT << 16) / den;  // 8.8 quotient of 240.0 / den
      h = ((q >> 8) >= `SCREEN_HEIGHT) ? 8'(`SCREEN_HEIGHT) : 8'(q >> 8);
    end
  endtask

  // hold the ray until accepted, then queue the model answer
  task automatic sendRay(input logic sx, input logic sy, input logic [15:0] dx,
                         input logic [15:0] dy, input logic [15:0] px, input logic [15:0] py,
                         input logic [15:0] sdx, input logic [15:0] sdy);
    logic [7:0] h;
    logic s;
    logic [3:0] t;
    {stepX, stepY, deltaDistX, deltaDistY} = {sx, sy, dx, dy};
    {posX, posY, sideDistX, sideDistY} = {px, py, sdx, sdy};
    hcount = colIdx;
    rayValid = 1'b1;
    @(negedge pixel_clk_in);
    while (!rayReady) @(negedge pixel_clk_in);
    modelRay(sx, sy, dx, dy, px, py, sdx, sdy, h, s, t);
    expQ.push_back({colIdx, h, s, t});
    colIdx++;
    sentCount++;
    @(posedge pixel_clk_in);
    #1;
    rayValid = 1'b0;
  endtask

  task automatic randomRay();
    logic [15:0] dx, dy;
    dx = 16'(128 + $urandom % 897);  // 0.5 .. 4.0
    dy = 16'(128 + $urandom % 897);
    sendRay($urandom % 2, $urandom % 2, dx, dy,
            {8'(1 + $urandom % 22), 8'($urandom)}, {8'(1 + $urandom % 22), 8'($urandom)},
            16'((dx * ($urandom % 256)) >> 8), 16'((dy * ($urandom % 256)) >> 8));
  endtask

  // start one tile in from the border, less than a tile from it
  task automatic wallRay(input int k);
    logic [15:0] near, far;
    // first half overflows the divider, second half lands on the clamp only
    near = (k < 4) ? 16'($urandom % 200) : 16'(241 + $urandom % 15);
    far = 16'(16'h0400 + $urandom % 256);
    if (k % 2 == 0) begin
      sendRay(1'b0, $urandom % 2, 16'h0100, 16'h0200,
              {8'd1, 8'($urandom)}, {8'(1 + $urandom % 22), 8'($urandom)}, near, far);
    end else begin
      sendRay($urandom % 2, 1'b1, 16'h0200, 16'h0100,
              {8'(1 + $urandom % 22), 8'($urandom)}, {8'd22, 8'($urandom)}, far, near);
    end
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0) begin
      @(posedge pixel_clk_in);
      #1;
    end
    checkVal("columns received", colCount, sentCount);  // none lost or duplicated
    checkVal("column valid after drain", colValid, 0);  // nothing behind the last one
  endtask

  task automatic endTest(input string name);
    if (errCount == errBefore) passCount++;
    else failCount++;
    $display("test %s: %s (%0d errors)", name, (errCount == errBefore) ? "ok" : "FAILED",
             errCount - errBefore);
    errBefore = errCount;
  endtask

  // outputs are stable at the falling edge, transfers happen at the next rise
  always @(negedge pixel_clk_in) begin
    if (!rst_in) begin
      gotCol = {colHcount, lineHeight, colSide, colTile};
      if (holding) begin
        assert (colValid && gotCol == heldCol) else begin
          $display("[ERROR] %0t: column output changed while stalled", $time);
          errCount++;
        end
      end
      if (colValid && colReady) begin
        colCount++;  // every handshake, expected or not
        assert (expQ.size() != 0) else begin
          $display("Column %0d came out with no ray pending", colHcount);
          errCount++;
        end
        if (expQ.size() != 0) begin
          expCol = expQ.pop_front();
          assert (gotCol == expCol) else begin
            $display("[ERROR] %0t: column got h%0d/%0d/%0d/%0d expected h%0d/%0d/%0d/%0d",
                     $time, colHcount, lineHeight, colSide, colTile,
                     expCol[21:13], expCol[12:5], expCol[4], expCol[3:0]);
            errCount++;
          end
        end
        if (wallTest) checkVal("wall line height", lineHeight, `SCREEN_HEIGHT);
      end
      holding = colValid && !colReady;
      heldCol = gotCol;
    end
  end

  initial begin
    forever begin
      @(posedge pixel_clk_in);
      #1;
      colReady = randomReady ? ($urandom % 4 != 0) : 1'b1;  // stall about one cycle in four
    end
  end

  always @(posedge pixel_clk_in) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: no finish after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst_in = 1'b1;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {rayValid, hcount, stepX, stepY, deltaDistX, deltaDistY} = '0;
    {posX, posY, sideDistX, sideDistY} = '0;
    colReady = 1'b1;
    {randomReady, wallTest, holding} = '0;
    {errCount, passCount, failCount, errBefore, sentCount, colCount, cycles} = '0;
    colIdx = '0;
    void'($urandom(32'hf10b_0363));
    repeat (3) @(posedge pixel_clk_in);
    #1;
    rst_in = 1'b0;

    // border walls everywhere, interior about one in four
    for (int i = 0; i < `MAP_TILES; i++) begin
      if (i % `MAP_SIZE == 0 || i % `MAP_SIZE == `MAP_SIZE - 1 || i < `MAP_SIZE ||
          i >= `MAP_TILES - `MAP_SIZE) tbMap[i] = 4'(1 + $urandom % 15);
      else tbMap[i] = ($urandom % 4 == 0) ? 4'(1 + $urandom % 15) : 4'd0;
      apbAccess(1'b1, 12'(i), 32'(tbMap[i]), rdata, err);
      checkVal("map write pslverr", err, 0);
    end
    for (int i = 0; i < `MAP_TILES; i++) begin
      apbAccess(1'b0, 12'(i), '0, rdata, err);
      checkVal("map readback", rdata, 32'(tbMap[i]));
      checkVal("map read pslverr", err, 0);
    end
    endTest("1 map write and readback");

    // 0x800 + k aliases tile k in the low bits
    for (int k = 0; k < 4; k++) begin
      apbAccess(1'b1, 12'(12'h800 + 5 * k), 32'(~tbMap[5 * k]), rdata, err);
      checkVal("unmapped write pslverr", err, 1);
      apbAccess(1'b0, 12'(5 * k), '0, rdata, err);
      checkVal("tile after unmapped write", rdata, 32'(tbMap[5 * k]));
    end
    apbAccess(1'b1, 12'd600, 32'hf, rdata, err);
    checkVal("write past map pslverr", err, 1);
    apbAccess(1'b0, 12'h7ff, '0, rdata, err);
    checkVal("unmapped read pslverr", err, 1);
    apbAccess(1'b0, `STATUS_ADDR, '0, rdata, err);
    checkVal("status idle", rdata, 0);
    checkVal("status pslverr", err, 0);
    randomRay();  // engine 0 is still stepping during the next read
    apbAccess(1'b0, `STATUS_ADDR, '0, rdata, err);
    checkVal("status busy", rdata, 32'd1 << STATUS_BUSY0);
    waitDrain();
    endTest("2 slave error and status");

    repeat (200) randomRay();
    waitDrain();
    endTest("3 random rays");

    randomReady = 1'b1;
    repeat (100) randomRay();
    waitDrain();
    randomReady = 1'b0;
    endTest("4 order under back-pressure");

    wallTest = 1'b1;
    for (int k = 0; k < 8; k++) wallRay(k);
    waitDrain();
    wallTest = 1'b0;
    endTest("5 wall close up");

    $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/rayPkg.sv
source/busPkg.sv
source/fixedDivider.sv
source/ddaEngine.sv
source/mapMemory.sv
source/columnSequencer.sv
source/raycasterTop.sv
test/raycasterTb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module raycasterTb -o raycasterSim &&
./obj_dir/raycasterSim | tee /dev/stderr | grep -qx "Simulation passed" &&
echo "run.sh: PASS" ||
{
  echo "run.sh: FAIL"
  exit 1
}
